//--- common/donkey_pkg.sv
// Barrel subsystem constants
// Coordinate width, sprite box sizes and motion timing shared by
// the geometry, collision and motion blocks.

`default_nettype none

package donkey_pkg;

    // screen coordinates
    localparam int coord_w = 11;

    typedef logic [coord_w-1:0] coord_t;

    // barrel sprite box
    localparam coord_t barrel_w = 32;
    localparam coord_t barrel_h = 32;

    // player sprite box
    localparam coord_t player_w = 48;
    localparam coord_t player_h = 60;

    // cycles per step, minus one
    localparam int step_w = 4;
    localparam logic [step_w-1:0] move_period = 3;
    localparam logic [step_w-1:0] fall_period = 3;

    // barrel retires on this landing
    localparam int landing_w = 2;
    localparam logic [landing_w-1:0] max_landings = 3;

    // top girder surface, where barrels appear
    localparam coord_t start_ypos = 208;

endpackage

`default_nettype wire

//--- common/platform_pkg.sv
// Playfield geometry
// Girder rows, slope steps and open ends of the barrel playfield.
// Heights are given as barrel top-left y when resting on the surface.

`default_nettype none

package platform_pkg;

    // what the barrel stands on
    typedef enum logic [1:0] {
        plat_none        = 2'b00,
        plat_slope_left  = 2'b01,
        plat_slope_right = 2'b10
    } platform_kind_t;

    localparam int num_rows = 4;
    localparam int row_w = $clog2(num_rows);

    // surface height at each row's high end
    localparam donkey_pkg::coord_t row_top [num_rows] = '{208, 324, 440, 556};

    // one slope step: this many pixels wide, drops this many pixels
    localparam donkey_pkg::coord_t platform_width = 64;
    localparam donkey_pkg::coord_t platform_offset = 2;

    // even rows open past the right end, odd rows below the left end
    localparam donkey_pkg::coord_t row_left_end = 96;
    localparam donkey_pkg::coord_t row_right_end = 800;

    // slope step index of each end
    localparam donkey_pkg::coord_t left_step = row_left_end / platform_width;
    localparam donkey_pkg::coord_t right_step = row_right_end / platform_width;

    // ground below the last row
    localparam donkey_pkg::coord_t floor_ypos = 672;

endpackage

`default_nettype wire

//--- src/map_control.sv
// Platform geometry lookup
// Picks the girder row under the barrel's bottom edge, reports its
// rolling direction and whether the barrel has passed its open end,
// and gives the surface height of the row below at the current x.
// All outputs are registered.

`timescale 1ns/1ps
`default_nettype none

module map_control (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [donkey_pkg::coord_w-1:0] xpos,
    input  logic [donkey_pkg::coord_w-1:0] ypos,
    output platform_pkg::platform_kind_t   platform,
    output logic                           end_of_platform,
    output logic [donkey_pkg::coord_w-1:0] landing_ypos
);

    logic [donkey_pkg::coord_w:0]     bottom;
    logic [platform_pkg::row_w-1:0]   row_idx;
    logic                             on_floor;
    donkey_pkg::coord_t               step;
    platform_pkg::platform_kind_t     platform_nxt;
    logic                             end_nxt;
    donkey_pkg::coord_t               landing_nxt;

    // sloped surface height of a row at a given slope step
    function automatic donkey_pkg::coord_t surface_y(
        input logic [platform_pkg::row_w-1:0] row,
        input donkey_pkg::coord_t             slope_step
    );
        donkey_pkg::coord_t drop;
        if (row[0] == 1'b0) begin
            // even rows are high at the left
            drop = (slope_step > platform_pkg::left_step) ?
                platform_pkg::platform_offset * (slope_step - platform_pkg::left_step) : '0;
        end else begin
            drop = (slope_step < platform_pkg::right_step) ?
                platform_pkg::platform_offset * (platform_pkg::right_step - slope_step) : '0;
        end
        return platform_pkg::row_top[row] + drop;
    endfunction

    always_comb begin : row_sel_blk
        bottom = {1'b0, ypos} + {1'b0, donkey_pkg::barrel_h};
        row_idx = '0;
        for (int r = 1; r < platform_pkg::num_rows; r++) begin
            if (bottom >= {1'b0, platform_pkg::row_top[r]} + {1'b0, donkey_pkg::barrel_h}) begin
                row_idx = r[platform_pkg::row_w-1:0];
            end
        end
        on_floor = (bottom >= {1'b0, platform_pkg::floor_ypos} + {1'b0, donkey_pkg::barrel_h});
        step = xpos / platform_pkg::platform_width;
    end

    always_comb begin : geo_comb_blk
        if (on_floor) begin
            platform_nxt = platform_pkg::plat_none;
            end_nxt = 1'b0;
        end else if (row_idx[0] == 1'b0) begin
            platform_nxt = platform_pkg::plat_slope_right;
            end_nxt = (xpos > platform_pkg::row_right_end);
        end else begin
            platform_nxt = platform_pkg::plat_slope_left;
            end_nxt = (xpos < platform_pkg::row_left_end);
        end

        // nothing below the last row but the ground
        if (on_floor || (row_idx == platform_pkg::num_rows - 1)) begin
            landing_nxt = platform_pkg::floor_ypos;
        end else begin
            landing_nxt = surface_y(row_idx + 1'b1, step);
        end
    end

    always_ff @(posedge clk) begin : geo_reg_blk
        if (rst) begin
            platform <= platform_pkg::plat_none;
            end_of_platform <= 1'b0;
            landing_ypos <= platform_pkg::floor_ypos;
        end else begin
            platform <= platform_nxt;
            end_of_platform <= end_nxt;
            landing_ypos <= landing_nxt;
        end
    end

endmodule

`default_nettype wire

//--- barrel/barrel_hit.sv
// Barrel to player collision test
// Strict bounding-box overlap on both axes; boxes that only touch
// along an edge do not collide. Result is registered.

`timescale 1ns/1ps
`default_nettype none

module barrel_hit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [donkey_pkg::coord_w-1:0] xpos,
    input  logic [donkey_pkg::coord_w-1:0] ypos,
    input  logic [donkey_pkg::coord_w-1:0] xpos_player,
    input  logic [donkey_pkg::coord_w-1:0] ypos_player,
    output logic                           overlap
);

    // one extra bit so the far edges never wrap
    logic [donkey_pkg::coord_w:0] barrel_left;
    logic [donkey_pkg::coord_w:0] barrel_top;
    logic [donkey_pkg::coord_w:0] barrel_right;
    logic [donkey_pkg::coord_w:0] barrel_bottom;
    logic [donkey_pkg::coord_w:0] player_left;
    logic [donkey_pkg::coord_w:0] player_top;
    logic [donkey_pkg::coord_w:0] player_right;
    logic [donkey_pkg::coord_w:0] player_bottom;
    logic                         x_overlap;
    logic                         y_overlap;

    always_comb begin : box_blk
        barrel_left = {1'b0, xpos};
        barrel_top = {1'b0, ypos};
        barrel_right = {1'b0, xpos} + {1'b0, donkey_pkg::barrel_w};
        barrel_bottom = {1'b0, ypos} + {1'b0, donkey_pkg::barrel_h};

        player_left = {1'b0, xpos_player};
        player_top = {1'b0, ypos_player};
        player_right = {1'b0, xpos_player} + {1'b0, donkey_pkg::player_w};
        player_bottom = {1'b0, ypos_player} + {1'b0, donkey_pkg::player_h};
    end

    // right and bottom edges are exclusive
    always_comb begin : overlap_blk
        x_overlap = (barrel_left < player_right) && (player_left < barrel_right);
        y_overlap = (barrel_top < player_bottom) && (player_top < barrel_bottom);
    end

    always_ff @(posedge clk) begin : overlap_reg_blk
        if (rst) begin
            overlap <= 1'b0;
        end else begin
            overlap <= x_overlap && y_overlap;
        end
    end

endmodule

`default_nettype wire

//--- barrel/barrel_motion.sv
// Barrel motion FSM
// Launches a barrel at the ape's x on the top girder, rolls it one
// pixel per step down the slope, drops it with rising velocity off
// each open end and counts landings. The run ends with done, plus
// hit when the barrel meets the player.
// Geometry and overlap inputs lag the position by one cycle, so
// they are only acted on at step ticks.

`timescale 1ns/1ps
`default_nettype none

module barrel_motion (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           launch,
    input  logic [donkey_pkg::coord_w-1:0] xpos_kong,
    input  platform_pkg::platform_kind_t   platform,
    input  logic                           end_of_platform,
    input  logic [donkey_pkg::coord_w-1:0] landing_ypos,
    input  logic                           overlap,
    output logic [donkey_pkg::coord_w-1:0] xpos,
    output logic [donkey_pkg::coord_w-1:0] ypos,
    output logic                           busy,
    output logic                           hit,
    output logic                           done
);

    typedef enum logic [1:0] {
        st_idle,
        st_roll,
        st_fall
    } state_t;

    state_t                           state;
    state_t                           state_nxt;
    donkey_pkg::coord_t               xpos_nxt;
    donkey_pkg::coord_t               ypos_nxt;
    donkey_pkg::coord_t               start_x;
    donkey_pkg::coord_t               start_x_nxt;
    donkey_pkg::coord_t               velocity;
    donkey_pkg::coord_t               velocity_nxt;
    donkey_pkg::coord_t               x_right;
    donkey_pkg::coord_t               x_left;
    logic [donkey_pkg::coord_w:0]     fall_target;
    logic [donkey_pkg::step_w-1:0]    step_cnt;
    logic [donkey_pkg::step_w-1:0]    step_cnt_nxt;
    logic [donkey_pkg::landing_w-1:0] landings;
    logic [donkey_pkg::landing_w-1:0] landings_nxt;
    logic                             tick;
    logic                             hit_nxt;
    logic                             done_nxt;

    assign busy = (state != st_idle);

    always_comb begin : step_blk
        tick = (state == st_fall) ? (step_cnt == donkey_pkg::fall_period) :
                                    (step_cnt == donkey_pkg::move_period);
        x_right = xpos + 1'b1;
        x_left = xpos - 1'b1;
        fall_target = {1'b0, ypos} + {1'b0, velocity};
    end

    always_comb begin : motion_comb_blk
        state_nxt = state;
        xpos_nxt = xpos;
        ypos_nxt = ypos;
        start_x_nxt = start_x;
        velocity_nxt = velocity;
        step_cnt_nxt = step_cnt;
        landings_nxt = landings;
        hit_nxt = 1'b0;
        done_nxt = 1'b0;

        case (state)
            st_idle: begin
                // no new run in the done cycle
                if (launch && !done) begin
                    state_nxt = st_roll;
                    xpos_nxt = xpos_kong;
                    start_x_nxt = xpos_kong;
                    ypos_nxt = donkey_pkg::start_ypos;
                    velocity_nxt = '0;
                    step_cnt_nxt = '0;
                    landings_nxt = '0;
                end else begin
                    xpos_nxt = start_x;
                    ypos_nxt = donkey_pkg::start_ypos;
                end
            end

            st_roll: begin
                if (!tick) begin
                    step_cnt_nxt = step_cnt + 1'b1;
                end else begin
                    step_cnt_nxt = '0;
                    if (overlap) begin
                        state_nxt = st_idle;
                        hit_nxt = 1'b1;
                        done_nxt = 1'b1;
                    end else if (end_of_platform) begin
                        state_nxt = st_fall;
                        velocity_nxt = '0;
                    end else if (platform == platform_pkg::plat_slope_right) begin
                        xpos_nxt = x_right;
                        // drop one slope step when entering a new column
                        if ((x_right % platform_pkg::platform_width) == '0) begin
                            ypos_nxt = ypos + platform_pkg::platform_offset;
                        end
                    end else if (platform == platform_pkg::plat_slope_left) begin
                        xpos_nxt = x_left;
                        if ((xpos % platform_pkg::platform_width) == '0) begin
                            ypos_nxt = ypos + platform_pkg::platform_offset;
                        end
                    end
                end
            end

            st_fall: begin
                if (!tick) begin
                    step_cnt_nxt = step_cnt + 1'b1;
                end else begin
                    step_cnt_nxt = '0;
                    if (overlap) begin
                        state_nxt = st_idle;
                        hit_nxt = 1'b1;
                        done_nxt = 1'b1;
                    end else if (fall_target >= {1'b0, landing_ypos}) begin
                        // snap onto the row below
                        ypos_nxt = landing_ypos;
                        velocity_nxt = '0;
                        landings_nxt = landings + 1'b1;
                        if (landings_nxt == donkey_pkg::max_landings) begin
                            state_nxt = st_idle;
                            done_nxt = 1'b1;
                        end else begin
                            state_nxt = st_roll;
                        end
                    end else begin
                        ypos_nxt = fall_target[donkey_pkg::coord_w-1:0];
                        velocity_nxt = velocity + 1'b1;
                    end
                end
            end

            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin : motion_reg_blk
        if (rst) begin
            state <= st_idle;
            xpos <= '0;
            ypos <= donkey_pkg::start_ypos;
            start_x <= '0;
            velocity <= '0;
            step_cnt <= '0;
            landings <= '0;
            hit <= 1'b0;
            done <= 1'b0;
        end else begin
            state <= state_nxt;
            xpos <= xpos_nxt;
            ypos <= ypos_nxt;
            start_x <= start_x_nxt;
            velocity <= velocity_nxt;
            step_cnt <= step_cnt_nxt;
            landings <= landings_nxt;
            hit <= hit_nxt;
            done <= done_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/barrel_unit.sv
// Barrel subsystem top level
// Geometry and collision stages look at the current barrel position;
// the motion stage uses their registered results to move the barrel
// and reports busy, hit and done.

`timescale 1ns/1ps
`default_nettype none

module barrel_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           launch,
    input  logic [donkey_pkg::coord_w-1:0] xpos_kong,
    input  logic [donkey_pkg::coord_w-1:0] xpos_player,
    input  logic [donkey_pkg::coord_w-1:0] ypos_player,
    output logic [donkey_pkg::coord_w-1:0] xpos,
    output logic [donkey_pkg::coord_w-1:0] ypos,
    output logic                           busy,
    output logic                           hit,
    output logic                           done
);

    platform_pkg::platform_kind_t   platform;
    logic                           end_of_platform;
    logic [donkey_pkg::coord_w-1:0] landing_ypos;
    logic                           overlap;

    map_control geo0 (
        .clk             (clk),
        .rst             (rst),
        .xpos            (xpos),
        .ypos            (ypos),
        .platform        (platform),
        .end_of_platform (end_of_platform),
        .landing_ypos    (landing_ypos)
    );

    barrel_hit hit0 (
        .clk         (clk),
        .rst         (rst),
        .xpos        (xpos),
        .ypos        (ypos),
        .xpos_player (xpos_player),
        .ypos_player (ypos_player),
        .overlap     (overlap)
    );

    barrel_motion motion0 (
        .clk             (clk),
        .rst             (rst),
        .launch          (launch),
        .xpos_kong       (xpos_kong),
        .platform        (platform),
        .end_of_platform (end_of_platform),
        .landing_ypos    (landing_ypos),
        .overlap         (overlap),
        .xpos            (xpos),
        .ypos            (ypos),
        .busy            (busy),
        .hit             (hit),
        .done            (done)
    );

endmodule

`default_nettype wire

//--- bench/barrel_unit_tb.sv
// Barrel subsystem testbench
// Replays barrel runs from a trace file, checks launch, busy, hit and
// done timing, the position at the end of each run, and the roll rules
// cycle by cycle while a barrel is in flight.

`timescale 1ns/1ps
`default_nettype none

module barrel_unit_tb;

    localparam int clk_period = 40;
    localparam int reset_cycles = 10;
    localparam int step_cycles = int'(donkey_pkg::move_period) + 1;
    // three full rows plus room for the falls, one pixel per step
    localparam int run_bound = 3 * (int'(platform_pkg::row_right_end) +
        int'(platform_pkg::platform_width)) * step_cycles + 16;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           launch;
    logic [donkey_pkg::coord_w-1:0] xpos_kong;
    logic [donkey_pkg::coord_w-1:0] xpos_player;
    logic [donkey_pkg::coord_w-1:0] ypos_player;
    logic [donkey_pkg::coord_w-1:0] xpos;
    logic [donkey_pkg::coord_w-1:0] ypos;
    logic                           busy;
    logic                           hit;
    logic                           done;

    // one entry per trace line
    int kong_q[$];
    int px_q[$];
    int py_q[$];
    int hit_q[$];
    int fx_q[$];
    int fy_q[$];

    logic prev_busy = 1'b0;
    int   prev_x = 0;
    int   prev_y = 0;

    barrel_unit dut0 (
        .clk         (clk),
        .rst         (rst),
        .launch      (launch),
        .xpos_kong   (xpos_kong),
        .xpos_player (xpos_player),
        .ypos_player (ypos_player),
        .xpos        (xpos),
        .ypos        (ypos),
        .busy        (busy),
        .hit         (hit),
        .done        (done)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_trace();
        int               fd;
        int               cnt;
        int               k;
        int               px;
        int               py;
        int               h;
        int               fx;
        int               fy;
        logic [8*256-1:0] line;
        fd = $fopen("bench/barrel_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the trace file bench/barrel_trace.txt");
        end
        // column header lines do not scan as six numbers
        while ($fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%d %d %d %d %d %d", k, px, py, h, fx, fy);
            if (cnt == 6) begin
                kong_q.push_back(k);
                px_q.push_back(px);
                py_q.push_back(py);
                hit_q.push_back(h);
                fx_q.push_back(fx);
                fy_q.push_back(fy);
            end
        end
        $fclose(fd);
        if (kong_q.size() == 0) begin
            abort_run("the trace file holds no barrel runs");
        end
    endtask

    task automatic watchdog();
        longint limit_cycles;
        limit_cycles = reset_cycles + 4 + longint'(kong_q.size()) * (run_bound + 8);
        #(limit_cycles * clk_period);
        abort_run($sformatf("timeout, done never arrived within %0d cycles", limit_cycles));
    endtask

    task automatic run_barrel(input int n);
        @(posedge clk);
        xpos_kong <= donkey_pkg::coord_t'(kong_q[n]);
        xpos_player <= donkey_pkg::coord_t'(px_q[n]);
        ypos_player <= donkey_pkg::coord_t'(py_q[n]);
        launch <= 1'b1;
        @(posedge clk);
        launch <= 1'b0;
        @(negedge clk);
        check_value("busy", 1, busy);
        check_value("xpos at launch", kong_q[n], xpos);
        check_value("ypos at launch", donkey_pkg::start_ypos, ypos);

        // second request while the barrel is in flight
        @(posedge clk);
        xpos_kong <= donkey_pkg::coord_t'(kong_q[n] ^ 'h2aa);
        launch <= 1'b1;
        @(posedge clk);
        launch <= 1'b0;
        @(negedge clk);
        check_value("busy after ignored launch", 1, busy);

        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_value("hit", hit_q[n], hit);
        check_value("xpos at done", fx_q[n], xpos);
        check_value("ypos at done", fy_q[n], ypos);
        check_value("busy at done", 0, busy);
        if (hit_q[n] == 0) begin
            check_value("ypos at last landing",
                platform_pkg::row_top[platform_pkg::num_rows-1], ypos);
        end
        @(negedge clk);
        check_value("done after pulse", 0, done);
        check_value("hit after pulse", 0, hit);
    endtask

    // roll rules, checked on every x change while a barrel is in flight
    always @(negedge clk) begin : roll_monitor_blk
        int row;
        int r;
        int exp_x;
        int exp_y;
        if (!rst) begin
            check_value("hit without done", 0, hit && !done);
            if (prev_busy && busy) begin
                if (int'(ypos) < prev_y) begin
                    check_value("ypos never falling back", prev_y, ypos);
                end
                if (int'(xpos) != prev_x) begin
                    row = 0;
                    for (r = 1; r < platform_pkg::num_rows; r++) begin
                        if (prev_y >= int'(platform_pkg::row_top[r])) begin
                            row = r;
                        end
                    end
                    if (row % 2 == 0) begin
                        exp_x = prev_x + 1;
                        exp_y = prev_y;
                        if (exp_x % int'(platform_pkg::platform_width) == 0) begin
                            exp_y = prev_y + int'(platform_pkg::platform_offset);
                        end
                    end else begin
                        exp_x = prev_x - 1;
                        exp_y = prev_y;
                        if (prev_x % int'(platform_pkg::platform_width) == 0) begin
                            exp_y = prev_y + int'(platform_pkg::platform_offset);
                        end
                    end
                    check_value("xpos roll step", exp_x, xpos);
                    check_value("ypos roll step", exp_y, ypos);
                end
            end
            prev_busy = busy;
            prev_x = xpos;
            prev_y = ypos;
        end
    end

    initial begin : main_blk
        int unsigned seed;
        int          gap;
        int          n;
        rst = 1'b1;
        launch = 1'b0;
        xpos_kong = '0;
        xpos_player = '0;
        ypos_player = '0;
        seed = $urandom(74);

        load_trace();
        fork
            watchdog();
        join_none

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy after reset", 0, busy);
        check_value("hit after reset", 0, hit);
        check_value("done after reset", 0, done);
        check_value("xpos after reset", 0, xpos);
        check_value("ypos after reset", donkey_pkg::start_ypos, ypos);

        for (n = 0; n < kong_q.size(); n++) begin
            run_barrel(n);
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/barrel_trace.txt
# xpos_kong xpos_player ypos_player hit xpos_at_done ypos_at_done
# decimal pixels, one barrel run per line
100 1000 0 0 801 556
100 300 180 1 269 214
0 200 180 1 169 212
500 700 180 1 669 214
64 160 180 1 129 210
300 290 200 1 300 208
700 740 180 1 709 210
100 52 180 0 801 556
200 200 148 0 801 556
400 833 200 0 801 556
100 810 300 1 801 275
640 810 330 1 801 303
100 400 300 1 447 336
0 200 330 1 247 342
100 300 420 1 269 446
100 60 380 1 95 349
300 810 480 1 779 462
300 810 500 1 801 472
768 1500 1000 0 801 556
0 0 700 0 801 556
50 1800 100 0 801 556
333 0 0 0 801 556
600 1200 600 0 801 556
256 300 180 1 269 208
450 400 180 0 801 556

//--- files.f
common/donkey_pkg.sv
common/platform_pkg.sv
src/map_control.sv
barrel/barrel_hit.sv
barrel/barrel_motion.sv
src/barrel_unit.sv
bench/barrel_unit_tb.sv
